/* boxBounds.sv */
`timescale 1ns/1ps
// --------------------
// Box corners from center and half-size
// --------------------
module boxBounds (
    input  primitivePkg::fixed3T center,
    input  primitivePkg::fixedT  halfSize,
    input  logic                 applyOffset,
    input  primitivePkg::fixed3T offset,
    output primitivePkg::fixed3T boxMin,
    output primitivePkg::fixed3T boxMax
);
    import primitivePkg::*;

    fixed3T shift;
    fixed3T lowCorner;
    fixed3T highCorner;

    // Scene offset only for the selected box
    always_comb begin
        shift = applyOffset ? offset : '0;
    end

    // Center minus and plus half-size per axis
    always_comb begin
        lowCorner.x  = center.x - halfSize;
        lowCorner.y  = center.y - halfSize;
        lowCorner.z  = center.z - halfSize;
        highCorner.x = center.x + halfSize;
        highCorner.y = center.y + halfSize;
        highCorner.z = center.z + halfSize;
    end

    // --------------------
    // Offset both corners
    always_comb begin
        boxMin.x = lowCorner.x + shift.x;
        boxMin.y = lowCorner.y + shift.y;
        boxMin.z = lowCorner.z + shift.z;
        boxMax.x = highCorner.x + shift.x;
        boxMax.y = highCorner.y + shift.y;
        boxMax.z = highCorner.z + shift.z;
    end

endmodule

/* primitiveGolden.txt */
# type start end offX offY offZ, then per lane: index surface color(hex) g0 g1 g2 g3 g4 g5
# g is boxMin xyz then boxMax xyz for boxes, center xyz then radius for spheres, whole units
0 4 8 3 -2 5 4 1 64ff64 -256 -512 -256 256 0 256 5 3 ffff91 -7 1 -5 13 21 15
0 5 8 3 -2 5 5 3 ffff91 -7 1 -5 13 21 15 6 2 ff647d -20 0 40 20 40 80
1 0 1 0 0 0 0 1 ffff00 0 16 0 16 0 0 255 0 000000 0 0 0 0 0 0
0 6 7 0 0 0 6 2 ff647d -20 0 40 20 40 80 255 0 000000 0 0 0 0 0 0
1 3 8 0 0 0 3 1 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 128 255 0 0 0 255 0 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 0 2 0 0 0 0 1 000000 0 0 0 0 0 0 1 1 000000 0 0 0 0 0 0
1 0 4 1 1 1 0 1 ffff00 0 16 0 16 0 0 1 1 000000 0 0 0 0 0 0
0 4 5 0 0 0 4 1 64ff64 -256 -512 -256 256 0 256 255 0 000000 0 0 0 0 0 0
0 5 6 -4 8 0 5 3 ffff91 -14 11 -10 6 31 10 255 0 000000 0 0 0 0 0 0
0 2 8 0 0 0 2 1 000000 0 0 0 0 0 0 3 1 000000 0 0 0 0 0 0
1 2 8 0 0 0 2 1 000000 0 0 0 0 0 0 3 1 000000 0 0 0 0 0 0
1 5 8 0 0 0 255 0 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 200 255 0 0 0 255 0 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 3 8 2 2 2 3 1 000000 0 0 0 0 0 0 4 1 64ff64 -256 -512 -256 256 0 256
0 4 8 0 0 0 4 1 64ff64 -256 -512 -256 256 0 256 5 3 ffff91 -10 3 -10 10 23 10
1 1 2 0 0 0 1 1 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 5 7 0 0 0 5 3 ffff91 -10 3 -10 10 23 10 6 2 ff647d -20 0 40 20 40 80
1 0 2 9 9 9 0 1 ffff00 0 16 0 16 0 0 1 1 000000 0 0 0 0 0 0
0 6 8 1 2 3 6 2 ff647d -20 0 40 20 40 80 7 1 000000 0 0 0 0 0 0
0 1 1 0 0 0 255 0 000000 0 0 0 0 0 0 255 0 000000 0 0 0 0 0 0
0 4 6 -1 -1 -1 4 1 64ff64 -256 -512 -256 256 0 256 5 3 ffff91 -11 2 -11 9 22 9

/* primitiveLane.sv */
`timescale 1ns/1ps
// --------------------
// One query lane: bound check, surface pick, entry decode
// Results registered one cycle after the query
// --------------------
module primitiveLane (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     queryValid,
    input  primitivePkg::PrimType    primType,
    input  primitivePkg::primIndexT  laneIndex,
    input  primitivePkg::primIndexT  endIndex,
    input  primitivePkg::rawEntryT   boxEntry,
    input  primitivePkg::rawEntryT   sphereEntry,
    input  primitivePkg::fixed3T     offset,
    output primitivePkg::primIndexT  primIndex,
    output primitivePkg::SurfaceType surface,
    output primitivePkg::rgb8T       color,
    output primitivePkg::fixed3T     boxMin,
    output primitivePkg::fixed3T     boxMax,
    output primitivePkg::fixed3T     sphereCenter,
    output primitivePkg::fixedT      sphereRadius
);
    import primitivePkg::*;

    localparam int nullBit = $bits(primIndexT) - 1;

    primIndexT  tableSize;
    logic       indexValid;
    SurfaceType nextSurface;
    rawEntryT   entry;
    logic       applyOffset;
    fixed3T     boundsMin;
    fixed3T     boundsMax;

    // --------------------
    // Bound and null check
    always_comb begin
        tableSize  = (primType == ptAabb) ? primIndexT'(aabbEntries)
                                          : primIndexT'(sphereEntries);
        indexValid = !laneIndex[nullBit] && (laneIndex < endIndex)
                     && (laneIndex < tableSize);
    end

    // Refraction scene, absolute index decides the material
    always_comb begin
        if (!indexValid) begin
            nextSurface = stNone;
        end else if (laneIndex == primIndexT'(globalStartIdx + 1)) begin
            nextSurface = stDielectric;
        end else if (laneIndex == primIndexT'(globalStartIdx + 2)) begin
            nextSurface = stMetal;
        end else begin
            nextSurface = stLambertian;
        end
    end

    // Entry of the selected table
    always_comb begin
        entry       = (primType == ptAabb) ? boxEntry : sphereEntry;
        applyOffset = (laneIndex == primIndexT'(globalStartIdx + 1));
    end

    boxBounds bounds_i (
        .center     (boxEntry.position),
        .halfSize   (boxEntry.scale),
        .applyOffset(applyOffset),
        .offset     (offset),
        .boxMin     (boundsMin),
        .boxMax     (boundsMax)
    );

    // --------------------
    // Result registers
    always_ff @(posedge clk) begin
        if (rst) begin
            primIndex <= nullPrimIndex;
            surface   <= stNone;
        end else if (queryValid) begin
            primIndex <= indexValid ? laneIndex : nullPrimIndex;
            surface   <= nextSurface;
        end
    end

    // Payload, unused geometry held at zero
    always_ff @(posedge clk) begin
        if (queryValid) begin
            color <= entry.color;
            if (primType == ptAabb) begin
                boxMin       <= boundsMin;
                boxMax       <= boundsMax;
                sphereCenter <= '0;
                sphereRadius <= '0;
            end else begin
                boxMin       <= '0;
                boxMax       <= '0;
                sphereCenter <= sphereEntry.position;
                sphereRadius <= sphereEntry.scale;
            end
        end
    end

    // Null index and stNone always leave together
    surfaceTracksIndex: assert property (
        @(posedge clk) disable iff (rst)
        queryValid |=> ((surface == stNone) == primIndex[nullBit])
    ) else $error("lane surface %0d disagrees with index %0d", surface, primIndex);

endmodule

/* primitivePkg.sv */
// --------------------
// Primitive query types, sizes and the fixed scene
// --------------------
package primitivePkg;

    // --------------------
    // Sizes
    localparam int fracBits       = 16;
    localparam int laneCount      = 2;
    localparam int aabbEntries    = 8;
    localparam int sphereEntries  = 4;
    localparam int aabbAddrBits   = $clog2(aabbEntries);
    localparam int sphereAddrBits = $clog2(sphereEntries);
    // First global primitive in the box table
    localparam int globalStartIdx = 4;

    // --------------------
    // Types
    // Signed Q16.16
    typedef logic signed [31:0] fixedT;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } fixed3T;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    // Top bit set means no primitive
    typedef logic [7:0] primIndexT;
    localparam primIndexT nullPrimIndex = 8'hff;

    typedef enum logic [0:0] {ptAabb, ptSphere} PrimType;
    typedef enum logic [1:0] {stNone, stLambertian, stMetal, stDielectric} SurfaceType;

    // Position on top, then scale or radius, color in the low bits
    typedef struct packed {
        fixed3T position;
        fixedT  scale;
        rgb8T   color;
    } rawEntryT;

    // Integer to Q16.16
    function automatic fixedT toFixed(input int whole);
        return fixedT'(whole <<< fracBits);
    endfunction

    function automatic rawEntryT makeEntry(
        input int x,
        input int y,
        input int z,
        input int size,
        input int r,
        input int g,
        input int b
    );
        rawEntryT entry;
        entry.position.x = toFixed(x);
        entry.position.y = toFixed(y);
        entry.position.z = toFixed(z);
        entry.scale      = toFixed(size);
        entry.color.r    = 8'(r);
        entry.color.g    = 8'(g);
        entry.color.b    = 8'(b);
        return entry;
    endfunction

    // --------------------
    // Scene
    localparam rawEntryT groundBox    = makeEntry(0, -256, 0, 256, 100, 255, 100);
    localparam rawEntryT boxOne       = makeEntry(0, 13, 0, 10, 255, 255, 145);
    localparam rawEntryT boxTwo       = makeEntry(0, 20, 60, 20, 255, 100, 125);
    localparam rawEntryT globalSphere = makeEntry(0, 16, 0, 16, 255, 255, 0);

endpackage

/* primitiveStore.sv */
`timescale 1ns/1ps
// --------------------
// Read-only scene table for boxes and spheres
// One combinational read per lane
// --------------------
module primitiveStore (
    input  primitivePkg::primIndexT [primitivePkg::laneCount-1:0] readIndex,
    output primitivePkg::rawEntryT  [primitivePkg::laneCount-1:0] boxEntry,
    output primitivePkg::rawEntryT  [primitivePkg::laneCount-1:0] sphereEntry
);
    import primitivePkg::*;

    rawEntryT boxTable [aabbEntries];
    rawEntryT sphereTable [sphereEntries];

    // --------------------
    // Scene contents
    // Everything outside the global primitives stays empty
    always_comb begin
        for (int i = 0; i < aabbEntries; i++) begin
            boxTable[i] = '0;
        end
        // Ground, then the two boxes standing on it
        boxTable[globalStartIdx]     = groundBox;
        boxTable[globalStartIdx + 1] = boxOne;
        boxTable[globalStartIdx + 2] = boxTwo;
    end

    always_comb begin
        for (int i = 0; i < sphereEntries; i++) begin
            sphereTable[i] = '0;
        end
        sphereTable[0] = globalSphere;
    end

    // --------------------
    // Lane reads
    always_comb begin
        for (int n = 0; n < laneCount; n++) begin
            // Box side
            if (readIndex[n] < primIndexT'(aabbEntries)) begin
                boxEntry[n] = boxTable[readIndex[n][aabbAddrBits-1:0]];
            end else begin
                boxEntry[n] = '0;
            end
            // Sphere side, smaller table
            if (readIndex[n] < primIndexT'(sphereEntries)) begin
                sphereEntry[n] = sphereTable[readIndex[n][sphereAddrBits-1:0]];
            end else begin
                sphereEntry[n] = '0;
            end
        end
    end

    // --------------------
    // Checks
    // Every lane read stays inside the box table
    always_comb begin
        for (int n = 0; n < laneCount; n++) begin
            assert final (readIndex[n] < primIndexT'(aabbEntries))
            else $error("store read past box table, lane %0d index %0d",
                        n, readIndex[n]);
        end
    end

endmodule

/* primitiveUnit.f */
primitivePkg.sv
primitiveStore.sv
boxBounds.sv
primitiveLane.sv
primitiveUnit.sv
primitiveUnitTb.sv

/* primitiveUnit.sv */
`timescale 1ns/1ps
// --------------------
// Primitive query unit, one query port over two lanes
// --------------------
module primitiveUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     queryValid,
    input  primitivePkg::PrimType    primType,
    input  primitivePkg::primIndexT  startIndex,
    input  primitivePkg::primIndexT  endIndex,
    input  primitivePkg::fixed3T     offset,
    output logic                     resultValid,
    output primitivePkg::primIndexT  [primitivePkg::laneCount-1:0] primIndex,
    output primitivePkg::SurfaceType [primitivePkg::laneCount-1:0] surface,
    output primitivePkg::rgb8T       [primitivePkg::laneCount-1:0] color,
    output primitivePkg::fixed3T     [primitivePkg::laneCount-1:0] boxMin,
    output primitivePkg::fixed3T     [primitivePkg::laneCount-1:0] boxMax,
    output primitivePkg::fixed3T     [primitivePkg::laneCount-1:0] sphereCenter,
    output primitivePkg::fixedT      [primitivePkg::laneCount-1:0] sphereRadius
);
    import primitivePkg::*;

    primIndexT [laneCount-1:0] laneIndex;
    primIndexT [laneCount-1:0] readIndex;
    rawEntryT  [laneCount-1:0] boxEntry;
    rawEntryT  [laneCount-1:0] sphereEntry;

    // --------------------
    // Lane addressing
    // Null start reads from the table base instead
    always_comb begin
        for (int n = 0; n < laneCount; n++) begin
            laneIndex[n] = startIndex + primIndexT'(n);
            readIndex[n] = startIndex[$bits(primIndexT)-1] ? primIndexT'(n) : laneIndex[n];
        end
    end

    primitiveStore store_i (
        .readIndex  (readIndex),
        .boxEntry   (boxEntry),
        .sphereEntry(sphereEntry)
    );

    for (genvar n = 0; n < laneCount; n++) begin : laneGen
        primitiveLane lane_i (
            .clk         (clk),
            .rst         (rst),
            .queryValid  (queryValid),
            .primType    (primType),
            .laneIndex   (laneIndex[n]),
            .endIndex    (endIndex),
            .boxEntry    (boxEntry[n]),
            .sphereEntry (sphereEntry[n]),
            .offset      (offset),
            .primIndex   (primIndex[n]),
            .surface     (surface[n]),
            .color       (color[n]),
            .boxMin      (boxMin[n]),
            .boxMax      (boxMax[n]),
            .sphereCenter(sphereCenter[n]),
            .sphereRadius(sphereRadius[n])
        );
    end

    // Lanes register on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= queryValid;
        end
    end

endmodule

/* primitiveUnitTb.sv */
`timescale 1ns/1ps
// --------------------
// Testbench for the primitive query unit
// Replays golden queries and checks both lanes one cycle later
// --------------------
module primitiveUnitTb;
    import primitivePkg::*;

    localparam int maxLines   = 32;
    localparam int fieldCount = 24;
    localparam int seed       = 55499;

    logic                      clk;
    logic                      rst;
    logic                      queryValid;
    PrimType                   primType;
    primIndexT                 startIndex;
    primIndexT                 endIndex;
    fixed3T                    offset;
    logic                      resultValid;
    primIndexT  [laneCount-1:0] primIndex;
    SurfaceType [laneCount-1:0] surface;
    rgb8T       [laneCount-1:0] color;
    fixed3T     [laneCount-1:0] boxMin;
    fixed3T     [laneCount-1:0] boxMax;
    fixed3T     [laneCount-1:0] sphereCenter;
    fixedT      [laneCount-1:0] sphereRadius;

    // Golden rows, query fields then 9 fields per lane
    int   gold [maxLines][fieldCount];
    int   lineCount    = 0;
    logic goldenLoaded = 1'b0;

    // Run state
    int   pendingLines [$];
    logic sampledQuery = 1'b0;
    logic checking     = 1'b0;
    int   checkedCount = 0;
    int   testErrors   = 0;
    int   passCount    = 0;
    int   failCount    = 0;
    int   otherErrors  = 0;
    int   gap;

    primitiveUnit dut_i (
        .clk         (clk),
        .rst         (rst),
        .queryValid  (queryValid),
        .primType    (primType),
        .startIndex  (startIndex),
        .endIndex    (endIndex),
        .offset      (offset),
        .resultValid (resultValid),
        .primIndex   (primIndex),
        .surface     (surface),
        .color       (color),
        .boxMin      (boxMin),
        .boxMax      (boxMax),
        .sphereCenter(sphereCenter),
        .sphereRadius(sphereRadius)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Helpers
    // Whole units to Q16.16
    function automatic fixedT wholeToFixed(input int whole);
        return fixedT'(whole * 65536);
    endfunction

    function automatic fixed3T fixedVector(input int x, input int y, input int z);
        fixed3T v;
        v.x = wholeToFixed(x);
        v.y = wholeToFixed(y);
        v.z = wholeToFixed(z);
        return v;
    endfunction

    task automatic checkField(input string name, input logic [95:0] actual,
                              input logic [95:0] expected);
        assert (actual === expected)
        else begin
            $display("FAILED time %0d ns: %s expected %h got %h", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    // Hash lines are comments, colors in hex, the rest decimal
    task automatic readGolden();
        int    fd;
        int    got;
        string lineText;
        int    f [fieldCount];
        fd = $fopen("primitiveGolden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file primitiveGolden.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd) && lineCount < maxLines) begin
            lineText = "";
            got = $fgets(lineText, fd);
            if (got == 0 || lineText.len() < 2 || lineText.getc(0) == "#") continue;
            got = $sscanf(lineText,
                "%d %d %d %d %d %d %d %d %h %d %d %d %d %d %d %d %d %h %d %d %d %d %d %d",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                f[22], f[23]);
            if (got != fieldCount) begin
                $display("golden row %0d has %0d fields instead of %0d",
                         lineCount + 1, got, fieldCount);
                otherErrors++;
            end else begin
                for (int k = 0; k < fieldCount; k++) gold[lineCount][k] = f[k];
                lineCount++;
            end
        end
        $fclose(fd);
        if (lineCount == 0) begin
            $display("the golden file holds no queries");
            otherErrors++;
        end
    endtask

    // --------------------
    // Result check for golden row i
    task automatic compareResult(input int i);
        int     b;
        fixed3T expMin;
        fixed3T expMax;
        fixed3T expCenter;
        fixedT  expRadius;
        testErrors = 0;
        checkField("resultValid", 96'(resultValid), 96'(1'b1));
        for (int n = 0; n < laneCount; n++) begin
            b         = 6 + 9 * n;
            expMin    = '0;
            expMax    = '0;
            expCenter = '0;
            expRadius = '0;
            // Geometry columns mean corners for boxes, center and radius for spheres
            if (gold[i][0] == 0) begin
                expMin = fixedVector(gold[i][b+3], gold[i][b+4], gold[i][b+5]);
                expMax = fixedVector(gold[i][b+6], gold[i][b+7], gold[i][b+8]);
            end else begin
                expCenter = fixedVector(gold[i][b+3], gold[i][b+4], gold[i][b+5]);
                expRadius = wholeToFixed(gold[i][b+6]);
            end
            checkField($sformatf("primIndex[%0d]", n), 96'(primIndex[n]), 96'(gold[i][b]));
            checkField($sformatf("surface[%0d]", n), 96'(surface[n]), 96'(gold[i][b+1]));
            // Payload only defined for a live index, top bit clear
            if (gold[i][b] < 128) begin
                checkField($sformatf("color[%0d]", n), 96'(color[n]), 96'(gold[i][b+2]));
                checkField($sformatf("boxMin[%0d]", n), 96'(boxMin[n]), 96'(expMin));
                checkField($sformatf("boxMax[%0d]", n), 96'(boxMax[n]), 96'(expMax));
                checkField($sformatf("sphereCenter[%0d]", n), 96'(sphereCenter[n]),
                           96'(expCenter));
                checkField($sformatf("sphereRadius[%0d]", n), 96'(sphereRadius[n]),
                           96'(expRadius));
            end
        end
        checkedCount++;
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d: ok", i + 1);
        end else begin
            failCount++;
            $display("test %0d: %0d mismatches", i + 1, testErrors);
        end
    endtask

    // --------------------
    // Checker
    // Mirrors what the DUT sampled on the last edge
    always @(posedge clk) begin
        sampledQuery <= rst ? 1'b0 : queryValid;
    end

    initial begin
        wait (checking);
        forever begin
            @(negedge clk);
            if (sampledQuery) begin
                if (pendingLines.size() == 0) begin
                    $display("a query was sampled but no golden row was outstanding");
                    otherErrors++;
                end else begin
                    compareResult(pendingLines.pop_front());
                end
            end else begin
                assert (resultValid === 1'b0)
                else begin
                    $display("resultValid went high at %0d ns without a query before it", $time);
                    otherErrors++;
                end
            end
        end
    end

    // Timeout from the golden length
    initial begin
        wait (goldenLoaded === 1'b1);
        repeat (lineCount * 4 + 20) @(posedge clk);
        $display("watchdog expired after %0d cycles with results missing", lineCount * 4 + 20);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // Stimulus
    initial begin
        void'($urandom(seed));
        rst        <= 1'b1;
        queryValid <= 1'b0;
        primType   <= ptAabb;
        startIndex <= '0;
        endIndex   <= '0;
        offset     <= '0;
        readGolden();
        goldenLoaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Reset state before any query
        @(negedge clk);
        testErrors = 0;
        checkField("resultValid", 96'(resultValid), 96'(1'b0));
        for (int n = 0; n < laneCount; n++) begin
            checkField($sformatf("primIndex[%0d]", n), 96'(primIndex[n]), 96'(8'hff));
            checkField($sformatf("surface[%0d]", n), 96'(surface[n]), 96'(2'd0));
        end
        if (testErrors == 0) begin
            passCount++;
            $display("test 0 (reset): ok");
        end else begin
            failCount++;
            $display("test 0 (reset): %0d mismatches", testErrors);
        end
        checking = 1'b1;
        for (int i = 0; i < lineCount; i++) begin
            // Odd rows follow with no gap
            gap = (i % 2 == 1) ? 0 : $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                queryValid <= 1'b0;
            end
            @(posedge clk);
            queryValid <= 1'b1;
            primType   <= (gold[i][0] == 0) ? ptAabb : ptSphere;
            startIndex <= primIndexT'(gold[i][1]);
            endIndex   <= primIndexT'(gold[i][2]);
            offset     <= fixedVector(gold[i][3], gold[i][4], gold[i][5]);
            pendingLines.push_back(i);
        end
        @(posedge clk);
        queryValid <= 1'b0;
        wait (checkedCount == lineCount);
        $display("summary: %0d tests, %0d ok, %0d with mismatches, %0d other errors",
                 passCount + failCount, passCount, failCount, otherErrors);
        if (failCount == 0 && otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the primitive unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module primitiveUnitTb -f primitiveUnit.f
status=0
./obj_dir/VprimitiveUnitTb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0
